//--- rbf_unit.f
+incdir+src
+incdir+testbench
src/rbf_pkg.sv
src/rbf_diff_scaler.sv
src/rbf_product_fifo.sv
src/rbf_kernel_lookup.sv
src/rbf_unit.sv
testbench/tb_rbf_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the rbf_unit testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rbf_unit -f rbf_unit.f -o tb_rbf_unit

./obj_dir/tb_rbf_unit 2>&1 | tee "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
  echo "run failed, see $LOG"
  exit 1
fi

echo "run finished, see $LOG"

//--- src/rbf_defs.svh
`ifndef RBF_DEFS_SVH
`define RBF_DEFS_SVH

// Width of the x, grid and scale words and of the kernel result
`define RBF_DATA_W 16

// Fraction bits carried by x, grid and scale
`define RBF_FRAC 12

// Kernel ROM address width
`define RBF_ADDR_W 8

// Fraction bits of the ROM address
`define RBF_ADDR_FRAC 4

// Entries in the product FIFO, a power of two
`define RBF_FIFO_DEPTH 4

`endif

//--- src/rbf_diff_scaler.sv
`timescale 1ns/1ps
`default_nettype none

`include "rbf_defs.svh"

module rbf_diff_scaler (
  input  wire                    clk,
  input  wire                    rst_n,

  input  wire rbf_pkg::sample_t  x_data,
  input  wire                    x_valid,
  input  wire                    x_last,
  output logic                   x_ready,

  input  wire rbf_pkg::sample_t  grid_data,
  input  wire                    grid_valid,
  output logic                   grid_ready,

  input  wire rbf_pkg::scale_t   scale_data,
  input  wire                    scale_valid,
  output logic                   scale_ready,

  output rbf_pkg::product_t      prod_data,
  output logic                   prod_valid,
  output logic                   prod_last,
  input  wire                    prod_ready
);

  logic                        s1_valid;
  rbf_pkg::diff_t              s1_diff;
  rbf_pkg::scale_t             s1_scale;
  logic                        s1_last;

  logic                        s2_valid;
  rbf_pkg::product_t           s2_prod;
  logic                        s2_last;

  logic                        s1_advance;
  logic                        s2_advance;
  logic                        join_fire;
  logic signed [`RBF_DATA_W:0] delta;
  rbf_pkg::diff_t              abs_delta;

  // A stage moves when empty or when its word is taken
  assign s2_advance = !s2_valid || prod_ready;
  assign s1_advance = !s1_valid || s2_advance;

  // All three words are consumed together
  assign join_fire   = x_valid && grid_valid && scale_valid && s1_advance;
  assign x_ready     = join_fire;
  assign grid_ready  = join_fire;
  assign scale_ready = join_fire;

  // Sign extend before subtracting so the difference cannot wrap
  assign delta     = {x_data[`RBF_DATA_W-1], x_data} - {grid_data[`RBF_DATA_W-1], grid_data};
  assign abs_delta = delta[`RBF_DATA_W] ? rbf_pkg::diff_t'(-delta) : rbf_pkg::diff_t'(delta);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_advance) begin
        s1_valid <= join_fire;
      end
      if (s2_advance) begin
        s2_valid <= s1_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (join_fire) begin
      s1_diff  <= abs_delta;
      s1_scale <= scale_data;
      s1_last  <= x_last;
    end
    if (s2_advance && s1_valid) begin
      s2_prod <= s1_diff * s1_scale;
      s2_last <= s1_last;
    end
  end

  assign prod_data  = s2_prod;
  assign prod_valid = s2_valid;
  assign prod_last  = s2_last;

  a_prod_hold: assert property (@(posedge clk) disable iff (!rst_n)
    prod_valid && !prod_ready |=> prod_valid && $stable(prod_data) && $stable(prod_last));

endmodule

`default_nettype wire

//--- src/rbf_kernel_lookup.sv
`timescale 1ns/1ps
`default_nettype none

`include "rbf_defs.svh"

module rbf_kernel_lookup (
  input  wire                     clk,
  input  wire                     rst_n,

  input  wire rbf_pkg::product_t  prod_data,
  input  wire                     prod_last,
  input  wire                     prod_valid,
  output logic                    prod_ready,

  output rbf_pkg::result_t        rbf_data,
  output logic                    rbf_last,
  output logic                    rbf_valid,
  input  wire                     rbf_ready
);

  // Drop fraction bits down to the address format
  localparam int SHIFT     = 2 * `RBF_FRAC - `RBF_ADDR_FRAC;
  localparam int ROM_SIZE  = 1 << `RBF_ADDR_W;
  localparam int ADDR_MAX  = ROM_SIZE - 1;

  rbf_pkg::result_t  rom [ROM_SIZE];

  rbf_pkg::product_t scaled;
  rbf_pkg::addr_t    sat_addr;

  logic              s1_valid;
  rbf_pkg::addr_t    s1_addr;
  logic              s1_last;

  logic              s2_valid;
  rbf_pkg::result_t  s2_data;
  logic              s2_last;

  logic              s1_advance;
  logic              s2_advance;
  logic              take;

  // Kernel table, constant after elaboration
  for (genvar i = 0; i < ROM_SIZE; i++) begin : g_rom
    assign rom[i] = rbf_pkg::rbf_kernel(rbf_pkg::addr_t'(i));
  end

  assign scaled   = prod_data >> SHIFT;
  assign sat_addr = (scaled > ADDR_MAX) ? rbf_pkg::addr_t'(ADDR_MAX)
                                        : scaled[`RBF_ADDR_W-1:0];

  assign s2_advance = !s2_valid || rbf_ready;
  assign s1_advance = !s1_valid || s2_advance;
  assign prod_ready = s1_advance;
  assign take       = prod_valid && s1_advance;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_advance) begin
        s1_valid <= prod_valid;
      end
      if (s2_advance) begin
        s2_valid <= s1_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      s1_addr <= sat_addr;
      s1_last <= prod_last;
    end
    // ROM read register
    if (s2_advance && s1_valid) begin
      s2_data <= rom[s1_addr];
      s2_last <= s1_last;
    end
  end

  assign rbf_data  = s2_data;
  assign rbf_last  = s2_last;
  assign rbf_valid = s2_valid;

  a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rbf_valid && !rbf_ready |=> rbf_valid && $stable(rbf_data) && $stable(rbf_last));

endmodule

`default_nettype wire

//--- src/rbf_pkg.sv
`default_nettype none

`include "rbf_defs.svh"

package rbf_pkg;

  // Signed input sample or grid point
  typedef logic signed [`RBF_DATA_W-1:0] sample_t;

  // Unsigned scale
  typedef logic [`RBF_DATA_W-1:0] scale_t;

  // |x - g|, one bit wider than a sample
  typedef logic [`RBF_DATA_W:0] diff_t;

  // diff * scale, fraction bits add up to 2 * RBF_FRAC
  typedef logic [2*`RBF_DATA_W:0] product_t;

  typedef logic [`RBF_ADDR_W-1:0] addr_t;

  typedef logic [`RBF_DATA_W-1:0] result_t;

  // Inverted quadratic standing in for sech^2
  function automatic result_t rbf_kernel(input addr_t addr);
    result_t sq;
    sq = addr * addr;
    return result_t'(16'hffff) - sq;
  endfunction

endpackage

`default_nettype wire

//--- src/rbf_product_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "rbf_defs.svh"

module rbf_product_fifo (
  input  wire                     clk,
  input  wire                     rst_n,

  input  wire rbf_pkg::product_t  wr_data,
  input  wire                     wr_last,
  input  wire                     wr_valid,
  output logic                    wr_ready,

  output rbf_pkg::product_t       rd_data,
  output logic                    rd_last,
  output logic                    rd_valid,
  input  wire                     rd_ready
);

  localparam int DEPTH = `RBF_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  rbf_pkg::product_t mem_data [DEPTH];
  logic              mem_last [DEPTH];

  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    count;
  logic              full;
  logic              wr_en;
  logic              rd_en;

  assign full     = (count == (PTR_W+1)'(DEPTH));
  assign rd_valid = (count != '0);
  // A full FIFO still takes a word in the cycle one leaves
  assign wr_ready = !full || rd_ready;
  assign wr_en    = wr_valid && wr_ready;
  assign rd_en    = rd_valid && rd_ready;

  assign rd_data = mem_data[rd_ptr];
  assign rd_last = mem_last[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_data[wr_ptr] <= wr_data;
      mem_last[wr_ptr] <= wr_last;
    end
  end

  // Pointers wrap naturally since depth is a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  // Occupancy never leaves 0 to DEPTH
  a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
    count <= (PTR_W+1)'(DEPTH));

  // Pointer distance tracks the occupancy
  a_ptr_count: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_ptr - rd_ptr) == count[PTR_W-1:0]);

endmodule

`default_nettype wire

//--- src/rbf_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rbf_defs.svh"

module rbf_unit (
  input  wire                    clk,
  input  wire                    rst_n,

  input  wire rbf_pkg::sample_t  x_data,
  input  wire                    x_valid,
  input  wire                    x_last,
  output logic                   x_ready,

  input  wire rbf_pkg::sample_t  grid_data,
  input  wire                    grid_valid,
  output logic                   grid_ready,

  input  wire rbf_pkg::scale_t   scale_data,
  input  wire                    scale_valid,
  output logic                   scale_ready,

  output rbf_pkg::result_t       rbf_data,
  output logic                   rbf_last,
  output logic                   rbf_valid,
  input  wire                    rbf_ready
);

  // Producer to FIFO
  rbf_pkg::product_t prod_data;
  logic              prod_last;
  logic              prod_valid;
  logic              prod_ready;

  // FIFO to lookup
  rbf_pkg::product_t fifo_data;
  logic              fifo_last;
  logic              fifo_valid;
  logic              fifo_ready;

  rbf_diff_scaler rbf_diff_scaler_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .x_data      (x_data),
    .x_valid     (x_valid),
    .x_last      (x_last),
    .x_ready     (x_ready),
    .grid_data   (grid_data),
    .grid_valid  (grid_valid),
    .grid_ready  (grid_ready),
    .scale_data  (scale_data),
    .scale_valid (scale_valid),
    .scale_ready (scale_ready),
    .prod_data   (prod_data),
    .prod_valid  (prod_valid),
    .prod_last   (prod_last),
    .prod_ready  (prod_ready)
  );

  rbf_product_fifo rbf_product_fifo_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_data  (prod_data),
    .wr_last  (prod_last),
    .wr_valid (prod_valid),
    .wr_ready (prod_ready),
    .rd_data  (fifo_data),
    .rd_last  (fifo_last),
    .rd_valid (fifo_valid),
    .rd_ready (fifo_ready)
  );

  rbf_kernel_lookup rbf_kernel_lookup_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .prod_data  (fifo_data),
    .prod_last  (fifo_last),
    .prod_valid (fifo_valid),
    .prod_ready (fifo_ready),
    .rbf_data   (rbf_data),
    .rbf_last   (rbf_last),
    .rbf_valid  (rbf_valid),
    .rbf_ready  (rbf_ready)
  );

endmodule

`default_nettype wire

//--- testbench/tb_rbf_model.svh
`ifndef TB_RBF_MODEL_SVH
`define TB_RBF_MODEL_SVH

`include "rbf_defs.svh"

// Product carries 2*RBF_FRAC fraction bits, the address keeps RBF_ADDR_FRAC
localparam int MODEL_SHIFT    = 2 * `RBF_FRAC - `RBF_ADDR_FRAC;
localparam int MODEL_ADDR_MAX = (1 << `RBF_ADDR_W) - 1;

function automatic int model_abs_diff(input logic signed [15:0] x,
                                      input logic signed [15:0] g);
  int d;
  d = int'(x) - int'(g);
  if (d < 0) begin
    d = -d;
  end
  return d;
endfunction

function automatic int model_address(input int diff, input logic [15:0] scale);
  longint prod;
  longint addr;
  prod = longint'(diff) * longint'(scale);
  addr = prod >> MODEL_SHIFT;
  if (addr > MODEL_ADDR_MAX) begin
    addr = MODEL_ADDR_MAX;
  end
  return int'(addr);
endfunction

// 65535 minus the square of the address
function automatic logic [15:0] model_kernel(input int addr);
  return 16'(65535 - addr * addr);
endfunction

function automatic logic [15:0] model_rbf(input logic signed [15:0] x,
                                          input logic signed [15:0] g,
                                          input logic [15:0] s);
  return model_kernel(model_address(model_abs_diff(x, g), s));
endfunction

`endif

//--- testbench/tb_rbf_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rbf_unit;

  `include "tb_rbf_model.svh"

  localparam int N_DIRECTED  = 20;
  localparam int N_RANDOM    = 200;
  localparam int N_BACKPR    = 200;
  localparam int N_FRAMES    = 120;
  localparam int N_TOTAL     = N_DIRECTED + N_RANDOM + N_BACKPR + N_FRAMES;
  localparam int CYCLE_LIMIT = 30 * N_TOTAL + 200;

  logic        clk;
  logic        rst_n;
  logic [15:0] x_data;
  logic        x_valid;
  logic        x_last;
  wire         x_ready;
  logic [15:0] grid_data;
  logic        grid_valid;
  wire         grid_ready;
  logic [15:0] scale_data;
  logic        scale_valid;
  wire         scale_ready;
  wire  [15:0] rbf_data;
  wire         rbf_last;
  wire         rbf_valid;
  logic        rbf_ready;

  // Pending stimulus with x entries packed as {last, sample}
  logic [16:0] x_q[$];
  logic [15:0] grid_q[$];
  logic [15:0] scale_q[$];
  // Expected {last, value} pairs in join order
  logic [16:0] exp_q[$];
  logic [16:0] exp_word;

  logic        x_fire;
  logic        grid_fire;
  logic        scale_fire;
  integer      seed;
  int          errors;
  int          checks;
  int          joined;
  int          results;
  int          cycles;
  int          in_stall_pct;
  int          out_stall_pct;

  rbf_unit rbf_unit_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .x_data      (x_data),
    .x_valid     (x_valid),
    .x_last      (x_last),
    .x_ready     (x_ready),
    .grid_data   (grid_data),
    .grid_valid  (grid_valid),
    .grid_ready  (grid_ready),
    .scale_data  (scale_data),
    .scale_valid (scale_valid),
    .scale_ready (scale_ready),
    .rbf_data    (rbf_data),
    .rbf_last    (rbf_last),
    .rbf_valid   (rbf_valid),
    .rbf_ready   (rbf_ready)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic int rand_pct();
    return $unsigned($random(seed)) % 100;
  endfunction

  // Handshakes are sampled mid-cycle and take effect at the next rising edge
  always @(negedge clk) begin
    x_fire     = rst_n && x_valid && x_ready;
    grid_fire  = rst_n && grid_valid && grid_ready;
    scale_fire = rst_n && scale_valid && scale_ready;
    if (x_ready != grid_ready || x_ready != scale_ready) begin
      $display("error at %0t: the three input readies disagree", $time);
      errors++;
    end
    if (rst_n && x_ready && !(x_valid && grid_valid && scale_valid)) begin
      $display("error at %0t: input readies high without all three valids", $time);
      errors++;
    end
    if (x_fire && grid_fire && scale_fire) begin
      exp_q.push_back({x_last, model_rbf(x_data, grid_data, scale_data)});
      joined++;
    end
    if (joined == 0 && rbf_valid !== 1'b0) begin
      $display("error at %0t: rbf_valid = %b, expected 0", $time, rbf_valid);
      errors++;
    end
    if (rst_n && rbf_valid && rbf_ready) begin
      results++;
      if (exp_q.size() == 0) begin
        $display("error at %0t: result came out with no joined triple pending", $time);
        errors++;
      end else begin
        exp_word = exp_q.pop_front();
        checks++;
        if (rbf_data !== exp_word[15:0]) begin
          $display("error at %0t: rbf_data = %0d, expected %0d", $time, rbf_data,
                   exp_word[15:0]);
          errors++;
        end
        if (rbf_last !== exp_word[16]) begin
          $display("error at %0t: rbf_last = %b, expected %b", $time, rbf_last, exp_word[16]);
          errors++;
        end
      end
    end
  end

  // Each stream holds its word until it moves and then stalls at random
  always @(posedge clk) begin
    #1;
    if (x_fire) begin
      x_q.delete(0);
      x_valid = 1'b0;
    end
    if (grid_fire) begin
      grid_q.delete(0);
      grid_valid = 1'b0;
    end
    if (scale_fire) begin
      scale_q.delete(0);
      scale_valid = 1'b0;
    end
    if (!x_valid && x_q.size() > 0 && rand_pct() >= in_stall_pct) begin
      x_data  = x_q[0][15:0];
      x_last  = x_q[0][16];
      x_valid = 1'b1;
    end
    if (!grid_valid && grid_q.size() > 0 && rand_pct() >= in_stall_pct) begin
      grid_data  = grid_q[0];
      grid_valid = 1'b1;
    end
    if (!scale_valid && scale_q.size() > 0 && rand_pct() >= in_stall_pct) begin
      scale_data  = scale_q[0];
      scale_valid = 1'b1;
    end
    rbf_ready = (rand_pct() >= out_stall_pct);
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles with results still missing", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic queue_triple(input logic [15:0] x, input logic [15:0] g,
                              input logic [15:0] s, input logic last);
    x_q.push_back({last, x});
    grid_q.push_back(g);
    scale_q.push_back(s);
  endtask

  // Grid near x so that addresses spread over the whole table
  task automatic queue_random(input logic last);
    logic [15:0] x;
    logic [15:0] offset;
    logic [15:0] s;
    x      = 16'($random(seed));
    offset = 16'($random(seed) % 8192);
    s      = 16'($random(seed)) & 16'h7fff;
    queue_triple(x, x + offset, s, last);
  endtask

  task automatic drain();
    while (x_q.size() != 0 || grid_q.size() != 0 || scale_q.size() != 0 ||
           exp_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("test %s finished with %0d errors", name, errors - errors_before);
  endtask

  initial begin
    int          err_mark;
    int          joined_mark;
    int          results_mark;
    int          frame_len;
    int          sent;
    logic [15:0] v;
    seed          = 32'hf6d1;
    rst_n         = 1'b0;
    x_data        = '0;
    x_valid       = 1'b0;
    x_last        = 1'b0;
    grid_data     = '0;
    grid_valid    = 1'b0;
    scale_data    = '0;
    scale_valid   = 1'b0;
    rbf_ready     = 1'b0;
    x_fire        = 1'b0;
    grid_fire     = 1'b0;
    scale_fire    = 1'b0;
    errors        = 0;
    checks        = 0;
    joined        = 0;
    results       = 0;
    cycles        = 0;
    in_stall_pct  = 0;
    out_stall_pct = 0;

    err_mark = errors;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (6) @(posedge clk);
    report_test("reset", err_mark);

    err_mark = errors;
    in_stall_pct = 20;
    for (int i = 0; i < 4; i++) begin
      v = 16'($random(seed));
      queue_triple(v, v, 16'($random(seed)), 1'b0);
    end
    // Differences large enough to clamp the address at 255
    queue_triple(16'h7fff, 16'h8000, 16'hffff, 1'b0);
    queue_triple(16'h2000, 16'he000, 16'h4000, 1'b0);
    queue_triple(16'h8000, 16'h7fff, 16'h1000, 1'b0);
    queue_triple(16'h0000, 16'h4000, 16'h4000, 1'b1);
    // Scale of 1.0 steps the address by one per 256 of difference
    for (int k = 0; k < 12; k++) begin
      v = 16'($random(seed)) & 16'h0fff;
      queue_triple(v, v + 16'(k * 256 + k * 7), 16'h1000, 1'(k == 11));
    end
    drain();
    report_test("directed", err_mark);

    err_mark = errors;
    in_stall_pct = 40;
    for (int i = 0; i < N_RANDOM; i++) begin
      queue_random(1'($random(seed)));
    end
    drain();
    report_test("random input stalls", err_mark);

    err_mark     = errors;
    joined_mark  = joined;
    results_mark = results;
    in_stall_pct  = 10;
    out_stall_pct = 60;
    for (int i = 0; i < N_BACKPR; i++) begin
      queue_random(1'($random(seed)));
    end
    drain();
    if (results - results_mark != N_BACKPR || joined - joined_mark != N_BACKPR) begin
      $display("error at %0t: result count = %0d, expected %0d", $time,
               results - results_mark, N_BACKPR);
      errors++;
    end
    report_test("output back-pressure", err_mark);

    err_mark = errors;
    in_stall_pct  = 30;
    out_stall_pct = 30;
    sent = 0;
    while (sent < N_FRAMES) begin
      frame_len = 1 + $unsigned($random(seed)) % 8;
      if (frame_len > N_FRAMES - sent) begin
        frame_len = N_FRAMES - sent;
      end
      for (int j = 0; j < frame_len; j++) begin
        queue_random(1'(j == frame_len - 1));
      end
      sent += frame_len;
    end
    drain();
    report_test("frame marking", err_mark);

    $display("tests 5, checks %0d, joined %0d, results %0d, errors %0d",
             checks, joined, results, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
